/* logic/rv_csr_config.svh */
`ifndef RV_CSR_CONFIG_SVH
`define RV_CSR_CONFIG_SVH

// ----------------------------------------
// ISA extension switches
// ----------------------------------------
// Each switch is 1 when the extension is built in, 0 when it is not

`define RV_EXT_C 0              // Compressed instructions, also relaxes mepc alignment
`define RV_EXT_M 1              // Integer multiply and divide
`define RV_EXT_E 0              // Reduced register file base

// ----------------------------------------
// Timing and machine width
// ----------------------------------------

// Clock cycles per tick of the time counter
`define RV_TIME_DIVIDER 4

// MXL field of misa
`define RV_MISA_MXL 1           // 1 = XLEN 32

`endif

/* logic/rv_isa_pkg.sv */
package rv_isa_pkg;

    // ----------------------------------------
    // Basic RV32 words
    // ----------------------------------------

    typedef logic [31:0] data_t;        // One XLEN word
    typedef logic [4:0]  reg_index_t;   // Integer register index, x0 to x31

    // ----------------------------------------
    // Major opcode
    // ----------------------------------------

    // SYSTEM holds ECALL, EBREAK and all Zicsr instructions
    localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

    // ----------------------------------------
    // Zicsr funct3 codes
    // ----------------------------------------
    // Bit 2 selects the immediate form, bits 1:0 the operation
    // 000 is the ECALL/EBREAK group, 100 is reserved

    localparam logic [2:0] FUNCT3_CSRRW  = 3'b001;  // Swap
    localparam logic [2:0] FUNCT3_CSRRS  = 3'b010;  // Read and set bits
    localparam logic [2:0] FUNCT3_CSRRC  = 3'b011;  // Read and clear bits
    localparam logic [2:0] FUNCT3_CSRRWI = 3'b101;  // Swap with zimm
    localparam logic [2:0] FUNCT3_CSRRSI = 3'b110;  // Set bits from zimm
    localparam logic [2:0] FUNCT3_CSRRCI = 3'b111;  // Clear bits from zimm

endpackage

/* logic/rv_csr_pkg.sv */
package rv_csr_pkg;

    import rv_isa_pkg::*;

    // ----------------------------------------
    // CSR address map
    // ----------------------------------------

    typedef logic [11:0] csr_addr_t;

    // Machine information and trap setup
    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MISA     = 12'h301;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;

    // Machine trap handling
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;

    // Unprivileged counters, top bits 11 so read-only
    localparam csr_addr_t CSR_CYCLE    = 12'hC00;
    localparam csr_addr_t CSR_TIME     = 12'hC01;
    localparam csr_addr_t CSR_INSTRET  = 12'hC02;
    localparam csr_addr_t CSR_CYCLEH   = 12'hC80;  // Upper halves for RV32
    localparam csr_addr_t CSR_TIMEH    = 12'hC81;
    localparam csr_addr_t CSR_INSTRETH = 12'hC82;

    // ----------------------------------------
    // CSR operation
    // ----------------------------------------

    typedef enum logic [1:0] {
        CSR_OP_WRITE = 2'b01,   // Replace
        CSR_OP_SET   = 2'b10,   // OR in the operand
        CSR_OP_CLEAR = 2'b11    // AND with inverted operand
    } csr_op_t;

    // ----------------------------------------
    // mstatus, raw word or named fields
    // ----------------------------------------

    localparam logic [1:0] MPP_MACHINE = 2'b11;    // Only machine mode exists

    typedef union packed {
        data_t raw;                         // As moved by CSR instructions
        struct packed {
            logic [18:0] reserved_31_13;
            logic [1:0]  mpp;               // Previous privilege
            logic [2:0]  reserved_10_8;
            logic        mpie;              // Previous interrupt enable
            logic [2:0]  reserved_6_4;
            logic        mie;               // Global machine interrupt enable
            logic [2:0]  reserved_2_0;
        } fields;
    } mstatus_t;

endpackage

/* logic/rv_csr_counters.sv */
`timescale 1ns/1ps

`include "rv_csr_config.svh"

module rv_csr_counters (
    input  logic        i_clock,
    input  logic        i_reset,
    input  logic        i_retire,       // One pulse per retired instruction
    output logic [63:0] o_cycle,
    output logic [63:0] o_time,
    output logic [63:0] o_instret
);

    // Prescaler needs at least one bit even for a divider of 1
    localparam int PRESCALE_WIDTH =
        (`RV_TIME_DIVIDER > 1) ? $clog2(`RV_TIME_DIVIDER) : 1;
    localparam logic [PRESCALE_WIDTH-1:0] PRESCALE_LAST =
        PRESCALE_WIDTH'(`RV_TIME_DIVIDER - 1);

    logic [PRESCALE_WIDTH-1:0] prescale;   // Clocks within the current time tick
    logic                      time_tick;  // Last clock of a tick

    // ----------------------------------------
    // Cycle counter
    // ----------------------------------------

    // Free running, full 64 bits so the carry reaches the high half
    always_ff @(posedge i_clock) begin
        if (i_reset)
            o_cycle <= '0;
        else
            o_cycle <= o_cycle + 64'd1;
    end

    // ----------------------------------------
    // Time base
    // ----------------------------------------

    assign time_tick = (prescale == PRESCALE_LAST);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            prescale <= '0;
            o_time   <= '0;
        end else begin
            prescale <= time_tick ? '0 : prescale + 1'b1;   // Wrap each tick
            if (time_tick)
                o_time <= o_time + 64'd1;                   // Stays at cycle / divider
        end
    end

    // ----------------------------------------
    // Retired instructions
    // ----------------------------------------

    always_ff @(posedge i_clock) begin
        if (i_reset)
            o_instret <= '0;
        else if (i_retire)
            o_instret <= o_instret + 64'd1;     // Counted on the edge ending the pulse
    end

endmodule

/* logic/rv_csr_alu.sv */
`timescale 1ns/1ps

module rv_csr_alu
    import rv_isa_pkg::*;
    import rv_csr_pkg::*;
(
    input  csr_op_t i_op,
    input  data_t   i_operand,          // rs1 value or zero-extended zimm
    input  logic    i_source_zero,      // rs1 or zimm field is 0
    input  data_t   i_old_value,        // Current CSR contents
    output data_t   o_new_value,
    output logic    o_write_intent
);

    // ----------------------------------------
    // New value
    // ----------------------------------------

    always_comb begin
        case (i_op)
            CSR_OP_WRITE: o_new_value = i_operand;
            CSR_OP_SET:   o_new_value = i_old_value | i_operand;
            CSR_OP_CLEAR: o_new_value = i_old_value & ~i_operand;
            default:      o_new_value = i_old_value;    // Unused encoding
        endcase
    end

    // ----------------------------------------
    // Write intent
    // ----------------------------------------
    // Set and clear with a zero source field only read, so
    // "csrrs rd, csr, x0" never counts as a write, even on
    // read-only counters. Swap always writes.

    always_comb begin
        case (i_op)
            CSR_OP_WRITE: o_write_intent = 1'b1;
            CSR_OP_SET:   o_write_intent = !i_source_zero;
            CSR_OP_CLEAR: o_write_intent = !i_source_zero;
            default:      o_write_intent = 1'b0;
        endcase
    end

endmodule

/* logic/rv_csr_block.sv */
`timescale 1ns/1ps

`include "rv_csr_config.svh"

module rv_csr_block
    import rv_isa_pkg::*;
    import rv_csr_pkg::*;
(
    input  logic        i_clock,
    input  logic        i_reset,
    input  csr_addr_t   i_addr,
    input  logic        i_access,       // Legal request this cycle
    input  logic        i_write_intent,
    input  data_t       i_wr_data,
    input  logic [63:0] i_cycle,
    input  logic [63:0] i_time,
    input  logic [63:0] i_instret,
    output data_t       o_rd_data,
    output logic        o_illegal
);

    // ----------------------------------------
    // Constants
    // ----------------------------------------

    // misa, one bit per extension letter plus MXL on top
    localparam data_t MISA_VALUE =
        (data_t'(`RV_MISA_MXL) << 30)       |   // MXL
        (data_t'(1)            << 20)       |   // U
        (data_t'(`RV_EXT_M != 0) << 12)     |   // M
        (data_t'(1)            << 8)        |   // I
        (data_t'(`RV_EXT_E != 0) << 4)      |   // E
        (data_t'(`RV_EXT_C != 0) << 2);         // C

    // Without C, return addresses are 4-byte aligned
    localparam data_t MEPC_MASK = (`RV_EXT_C != 0) ? 32'hFFFF_FFFE : 32'hFFFF_FFFC;
    localparam data_t MTVEC_MASK = 32'hFFFF_FFFC;  // Direct mode, base only

    // ----------------------------------------
    // Storage
    // ----------------------------------------

    mstatus_t mstatus;
    data_t    mtvec;
    data_t    mepc;
    data_t    mcause;
    data_t    mscratch;

    mstatus_t mstatus_wr;       // Incoming word seen through the field view
    mstatus_t mstatus_next;     // Only the writable fields survive
    logic     known;            // Address is implemented
    logic     read_only;        // Top address bits 11
    logic     write_enable;

    // ----------------------------------------
    // Decode and read mux
    // ----------------------------------------

    always_comb begin
        known = 1'b1;
        case (i_addr)
            CSR_MSTATUS:  o_rd_data = mstatus.raw;
            CSR_MISA:     o_rd_data = MISA_VALUE;
            CSR_MTVEC:    o_rd_data = mtvec;
            CSR_MSCRATCH: o_rd_data = mscratch;
            CSR_MEPC:     o_rd_data = mepc;
            CSR_MCAUSE:   o_rd_data = mcause;
            CSR_CYCLE:    o_rd_data = i_cycle[31:0];
            CSR_TIME:     o_rd_data = i_time[31:0];
            CSR_INSTRET:  o_rd_data = i_instret[31:0];
            CSR_CYCLEH:   o_rd_data = i_cycle[63:32];
            CSR_TIMEH:    o_rd_data = i_time[63:32];
            CSR_INSTRETH: o_rd_data = i_instret[63:32];
            default: begin
                o_rd_data = '0;     // Unimplemented reads as zero
                known     = 1'b0;
            end
        endcase
    end

    assign read_only = (i_addr[11:10] == 2'b11);
    assign o_illegal = !known || (read_only && i_write_intent);

    // ----------------------------------------
    // Write path
    // ----------------------------------------

    always_comb begin
        mstatus_wr               = mstatus_t'(i_wr_data);
        mstatus_next             = '0;
        mstatus_next.fields.mie  = mstatus_wr.fields.mie;
        mstatus_next.fields.mpie = mstatus_wr.fields.mpie;
        mstatus_next.fields.mpp  = MPP_MACHINE;     // Hardwired, no lower modes
    end

    assign write_enable = i_access && i_write_intent && !o_illegal;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            mstatus            <= '0;
            mstatus.fields.mpp <= MPP_MACHINE;
            mtvec              <= '0;
            mepc               <= '0;
            mcause             <= '0;
            mscratch           <= '0;
        end else if (write_enable) begin
            case (i_addr)
                CSR_MSTATUS:  mstatus  <= mstatus_next;
                CSR_MTVEC:    mtvec    <= i_wr_data & MTVEC_MASK;
                CSR_MEPC:     mepc     <= i_wr_data & MEPC_MASK;
                CSR_MCAUSE:   mcause   <= i_wr_data;
                CSR_MSCRATCH: mscratch <= i_wr_data;
                default: ;                  // misa ignores writes (WARL)
            endcase
        end
    end

endmodule

/* logic/rv_csr_unit.sv */
`timescale 1ns/1ps

module rv_csr_unit
    import rv_isa_pkg::*;
    import rv_csr_pkg::*;
(
    input  logic       i_clock,
    input  logic       i_reset,
    input  logic       i_valid,         // One-cycle request strobe
    input  logic       i_retire,
    input  data_t      i_instr,
    input  data_t      i_rs1_data,
    output logic       o_valid,         // One cycle after i_valid
    output data_t      o_rd_data,       // Old CSR value
    output reg_index_t o_rd_index,
    output logic       o_illegal
);

    // ----------------------------------------
    // Instruction fields
    // ----------------------------------------

    csr_addr_t  csr_addr;
    reg_index_t rs1_field;              // rs1 or zimm
    logic [2:0] funct3;
    reg_index_t rd_index;
    logic [6:0] opcode;

    assign csr_addr  = i_instr[31:20];
    assign rs1_field = i_instr[19:15];
    assign funct3    = i_instr[14:12];
    assign rd_index  = i_instr[11:7];
    assign opcode    = i_instr[6:0];

    csr_op_t op;
    logic    use_imm;
    logic    funct3_ok;
    logic    request_ok;            // SYSTEM opcode with a Zicsr funct3
    data_t   operand;
    data_t   old_value;
    data_t   new_value;
    logic    write_intent;
    logic    block_illegal;
    logic    illegal;

    logic [63:0] cycle_count;
    logic [63:0] time_count;
    logic [63:0] instret_count;

    // funct3 to operation, bit 2 picks zimm
    always_comb begin
        funct3_ok = 1'b1;
        use_imm   = funct3[2];
        case (funct3)
            FUNCT3_CSRRW, FUNCT3_CSRRWI: op = CSR_OP_WRITE;
            FUNCT3_CSRRS, FUNCT3_CSRRSI: op = CSR_OP_SET;
            FUNCT3_CSRRC, FUNCT3_CSRRCI: op = CSR_OP_CLEAR;
            default: begin
                op        = CSR_OP_WRITE;
                funct3_ok = 1'b0;           // 000 and reserved 100
            end
        endcase
    end

    assign operand    = use_imm ? data_t'(rs1_field) : i_rs1_data;  // zimm zero-extended
    assign request_ok = (opcode == OPCODE_SYSTEM) && funct3_ok;
    assign illegal    = !request_ok || block_illegal;

    // ----------------------------------------
    // Blocks
    // ----------------------------------------

    rv_csr_counters counters (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_retire  (i_retire),
        .o_cycle   (cycle_count),
        .o_time    (time_count),
        .o_instret (instret_count)
    );

    rv_csr_alu alu (
        .i_op           (op),
        .i_operand      (operand),
        .i_source_zero  (rs1_field == '0),
        .i_old_value    (old_value),
        .o_new_value    (new_value),
        .o_write_intent (write_intent)
    );

    rv_csr_block block (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_addr         (csr_addr),
        .i_access       (i_valid && request_ok),    // Only legal requests commit
        .i_write_intent (write_intent),
        .i_wr_data      (new_value),
        .i_cycle        (cycle_count),
        .i_time         (time_count),
        .i_instret      (instret_count),
        .o_rd_data      (old_value),
        .o_illegal      (block_illegal)
    );

    // ----------------------------------------
    // Result register
    // ----------------------------------------

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_valid   <= 1'b0;
            o_illegal <= 1'b0;
        end else begin
            o_valid   <= i_valid;
            o_illegal <= i_valid && illegal;
        end
    end

    // Payload, held between requests
    always_ff @(posedge i_clock) begin
        if (i_valid) begin
            o_rd_data  <= illegal ? '0 : old_value;     // Illegal reads return zero
            o_rd_index <= rd_index;
        end
    end

endmodule

/* test/rv_csr_clock.sv */
`timescale 1ns/1ps

module rv_csr_clock (
    output logic o_clock,
    output logic o_reset
);

    // 4 ns period
    initial begin
        o_clock = 1'b0;
        forever #2 o_clock = ~o_clock;
    end

    // Reset held over 4 rising edges, dropped on a falling edge
    initial begin
        o_reset = 1'b1;
        repeat (4) @(posedge o_clock);
        @(negedge o_clock);
        o_reset = 1'b0;
    end

endmodule

/* test/rv_csr_properties.sv */
`timescale 1ns/1ps

module rv_csr_properties
    import rv_isa_pkg::*;
(
    input logic  i_clock,
    input logic  i_reset,
    input logic  i_valid,
    input logic  i_out_valid,       // DUT o_valid
    input logic  i_out_illegal,     // DUT o_illegal
    input data_t i_rd_data          // DUT o_rd_data
);

    // ----------------------------------------
    // Result strobe timing
    // ----------------------------------------

    valid_delay: assert property (@(posedge i_clock) disable iff (i_reset)
        i_out_valid == $past(i_valid))
        else $error("o_valid is not i_valid delayed by one cycle");

    valid_in_reset: assert property (@(posedge i_clock)
        i_reset |=> !i_out_valid)                       // Cleared by every reset edge
        else $error("o_valid high while in reset");

    // ----------------------------------------
    // Illegal results
    // ----------------------------------------

    illegal_has_valid: assert property (@(posedge i_clock) disable iff (i_reset)
        i_out_illegal |-> i_out_valid)
        else $error("o_illegal without o_valid");

    illegal_reads_zero: assert property (@(posedge i_clock) disable iff (i_reset)
        (i_out_valid && i_out_illegal) |-> (i_rd_data == '0))
        else $error("Illegal result carries nonzero rd data");

endmodule

bind rv_csr_unit rv_csr_properties props (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_valid       (i_valid),
    .i_out_valid   (o_valid),
    .i_out_illegal (o_illegal),
    .i_rd_data     (o_rd_data)
);

/* test/rv_csr_tb.sv */
`timescale 1ns/1ps

`include "rv_csr_config.svh"

module rv_csr_tb
    import rv_isa_pkg::*;
    import rv_csr_pkg::*;
();

    typedef struct {
        string      name;
        logic [6:0] opcode;
        logic [2:0] funct3;
        csr_addr_t  addr;
        reg_index_t rd;
        reg_index_t rs1;        // Register number or zimm for immediate forms
        data_t      rs1_data;
        int         retires;    // i_retire strobes before the request
    } step_t;

    logic clock, reset;
    logic i_valid, i_retire, o_valid, o_illegal;
    data_t i_instr, i_rs1_data, o_rd_data;
    reg_index_t o_rd_index;

    step_t steps[$];
    int errors = 0;
    int checks = 0;
    int run_cycles = 0;
    int limit = 0;                  // Timeout in cycles from the table length
    longint unsigned model_cycles = 0;
    longint unsigned ref_retired = 0;
    data_t ref_mstatus = 32'h0000_1800;     // MPP 11 after reset
    data_t ref_mtvec = '0;
    data_t ref_mepc = '0;
    data_t ref_mcause = '0;
    data_t ref_mscratch = '0;

    rv_csr_clock clock_gen (.o_clock(clock), .o_reset(reset));

    rv_csr_unit uut (
        .i_clock    (clock),
        .i_reset    (reset),
        .i_valid    (i_valid),
        .i_retire   (i_retire),
        .i_instr    (i_instr),
        .i_rs1_data (i_rs1_data),
        .o_valid    (o_valid),
        .o_rd_data  (o_rd_data),
        .o_rd_index (o_rd_index),
        .o_illegal  (o_illegal)
    );

    // Cycles seen by the counters and the run length for the timeout
    always @(posedge clock) begin
        run_cycles <= run_cycles + 1;
        if (!reset)
            model_cycles <= model_cycles + 1;
    end

    always @(negedge clock) begin
        if (limit > 0 && run_cycles > limit) begin
            $display("Timeout after %0d cycles, the DUT gave no result", run_cycles);
            $display("sim failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------

    function automatic bit implemented(input csr_addr_t addr);
        return addr inside {CSR_MSTATUS, CSR_MISA, CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC,
                            CSR_MCAUSE, CSR_CYCLE, CSR_TIME, CSR_INSTRET, CSR_CYCLEH,
                            CSR_TIMEH, CSR_INSTRETH};
    endfunction

    function automatic data_t reference_read(input csr_addr_t addr);
        case (addr)
            CSR_MSTATUS:  return ref_mstatus;
            CSR_MISA:     return 32'h4010_1100;     // MXL 01, U, M, I
            CSR_MTVEC:    return ref_mtvec;
            CSR_MSCRATCH: return ref_mscratch;
            CSR_MEPC:     return ref_mepc;
            CSR_MCAUSE:   return ref_mcause;
            CSR_CYCLE:    return data_t'(model_cycles);
            CSR_TIME:     return data_t'(model_cycles / `RV_TIME_DIVIDER);
            CSR_INSTRET:  return data_t'(ref_retired);
            default:      return '0;                // High halves are zero in a short run
        endcase
    endfunction

    function automatic void reference_write(input csr_addr_t addr, input data_t value);
        case (addr)
            CSR_MSTATUS:  ref_mstatus  = 32'h0000_1800 | (value & 32'h0000_0088);  // MPIE, MIE
            CSR_MTVEC:    ref_mtvec    = value & ~32'h3;
            CSR_MEPC:     ref_mepc     = value & ((`RV_EXT_C != 0) ? ~32'h1 : ~32'h3);
            CSR_MCAUSE:   ref_mcause   = value;
            CSR_MSCRATCH: ref_mscratch = value;
            default: ;
        endcase
    endfunction

    // ----------------------------------------
    // Stimulus table
    // ----------------------------------------

    function automatic void add_step(input string name, input logic [6:0] opcode,
                                     input logic [2:0] funct3, input csr_addr_t addr,
                                     input reg_index_t rd, input reg_index_t rs1,
                                     input data_t rs1_data, input int retires);
        step_t s;
        s = '{name, opcode, funct3, addr, rd, rs1, rs1_data, retires};
        steps.push_back(s);
    endfunction

    function automatic void build_table();
        // Reset values and misa read with rs1 = x0
        add_step("reset mstatus", OPCODE_SYSTEM, FUNCT3_CSRRS, CSR_MSTATUS, 1, 0, '0, 0);
        add_step("reset mtvec", OPCODE_SYSTEM, FUNCT3_CSRRS, CSR_MTVEC, 2, 0, '0, 0);
        add_step("reset mepc", OPCODE_SYSTEM, FUNCT3_CSRRS, CSR_MEPC, 3, 0, '0, 0);
        add_step("reset mcause", OPCODE_SYSTEM, FUNCT3_CSRRS, CSR_MCAUSE, 4, 0, '0, 0);
        add_step("reset mscratch", OPCODE_SYSTEM, FUNCT3_CSRRS, CSR_MSCRATCH, 5, 0, '0, 0);
        add_step("reset instret", OPCODE_SYSTEM, FUNCT3_CSRRS, CSR_INSTRET, 6, 0, '0, 0);
        add_step("misa", OPCODE_SYSTEM, FUNCT3_CSRRS, CSR_MISA, 7, 0, '0, 0);
        // Swap twice so the second rd shows the first write after masking
        add_step("mscratch write", OPCODE_SYSTEM, FUNCT3_CSRRW, CSR_MSCRATCH, 8, 10, $urandom, 0);
        add_step("mscratch swap", OPCODE_SYSTEM, FUNCT3_CSRRW, CSR_MSCRATCH, 9, 11, $urandom, 0);
        add_step("mtvec write", OPCODE_SYSTEM, FUNCT3_CSRRW, CSR_MTVEC, 10, 12,
                 $urandom | 32'h3, 0);                  // Low bits set so the mask shows
        add_step("mtvec swap", OPCODE_SYSTEM, FUNCT3_CSRRW, CSR_MTVEC, 11, 13, $urandom, 0);
        add_step("mepc write", OPCODE_SYSTEM, FUNCT3_CSRRW, CSR_MEPC, 12, 14,
                 $urandom | 32'h3, 0);
        add_step("mepc swap", OPCODE_SYSTEM, FUNCT3_CSRRW, CSR_MEPC, 13, 15, $urandom, 0);
        add_step("mcause write", OPCODE_SYSTEM, FUNCT3_CSRRW, CSR_MCAUSE, 14, 16, $urandom, 0);
        add_step("mcause swap", OPCODE_SYSTEM, FUNCT3_CSRRW, CSR_MCAUSE, 15, 17, $urandom, 0);
        // Each mstatus step flips MIE or MPIE so its effect shows in the next rd
        add_step("mstatus setimm", OPCODE_SYSTEM, FUNCT3_CSRRSI, CSR_MSTATUS, 16, 8, '0, 0);
        add_step("mstatus set", OPCODE_SYSTEM, FUNCT3_CSRRS, CSR_MSTATUS, 17, 7,
                 $urandom | 32'h80, 0);
        add_step("mstatus clrimm", OPCODE_SYSTEM, FUNCT3_CSRRCI, CSR_MSTATUS, 18, 8, '0, 0);
        add_step("mstatus clear", OPCODE_SYSTEM, FUNCT3_CSRRC, CSR_MSTATUS, 19, 7,
                 $urandom | 32'h80, 0);
        add_step("mstatus swapimm", OPCODE_SYSTEM, FUNCT3_CSRRWI, CSR_MSTATUS, 20, 31, '0, 0);
        add_step("mstatus read", OPCODE_SYSTEM, FUNCT3_CSRRS, CSR_MSTATUS, 21, 0, '0, 0);
        // Counters
        add_step("cycle read", OPCODE_SYSTEM, FUNCT3_CSRRS, CSR_CYCLE, 22, 0, '0, 0);
        add_step("cycle later", OPCODE_SYSTEM, FUNCT3_CSRRS, CSR_CYCLE, 23, 0, '0, 3);
        add_step("time read", OPCODE_SYSTEM, FUNCT3_CSRRS, CSR_TIME, 24, 0, '0, 0);
        add_step("instret read", OPCODE_SYSTEM, FUNCT3_CSRRS, CSR_INSTRET, 25, 0, '0, 2);
        add_step("cycleh", OPCODE_SYSTEM, FUNCT3_CSRRS, CSR_CYCLEH, 26, 0, '0, 0);
        add_step("timeh", OPCODE_SYSTEM, FUNCT3_CSRRS, CSR_TIMEH, 27, 0, '0, 0);
        add_step("instreth", OPCODE_SYSTEM, FUNCT3_CSRRS, CSR_INSTRETH, 28, 0, '0, 0);
        // Illegal requests followed by reads that show no write happened
        add_step("unknown addr", OPCODE_SYSTEM, FUNCT3_CSRRS, 12'h7C0, 29, 0, '0, 0);
        add_step("write cycle", OPCODE_SYSTEM, FUNCT3_CSRRW, CSR_CYCLE, 30, 5, $urandom, 0);
        add_step("not system", 7'b0110011, FUNCT3_CSRRW, CSR_MSCRATCH, 31, 5, $urandom, 0);
        add_step("funct3 100", OPCODE_SYSTEM, 3'b100, CSR_MSCRATCH, 1, 5, $urandom, 0);
        add_step("mscratch kept", OPCODE_SYSTEM, FUNCT3_CSRRS, CSR_MSCRATCH, 2, 0, '0, 0);
        add_step("cycle kept", OPCODE_SYSTEM, FUNCT3_CSRRS, CSR_CYCLE, 3, 0, '0, 0);
    endfunction

    // ----------------------------------------
    // Driving and checking
    // ----------------------------------------

    task automatic check_value(input string signal, input data_t got, input data_t expected);
        checks++;
        assert (got === expected) else begin
            $display("[ERROR] %0t ns %s got %h expected %h", $time, signal, got, expected);
            errors++;
        end
    endtask

    task automatic run_step(input step_t s);
        data_t operand, old_value, new_value;
        bit is_write, is_imm, legal_op, write_intent, exp_illegal;
        repeat (s.retires) begin
            i_retire = 1'b1;                // Counted at the next rising edge
            @(negedge clock);
            ref_retired++;
        end
        i_retire = 1'b0;
        is_write = s.funct3 inside {FUNCT3_CSRRW, FUNCT3_CSRRWI};
        is_imm   = s.funct3 inside {FUNCT3_CSRRWI, FUNCT3_CSRRSI, FUNCT3_CSRRCI};
        legal_op = (s.opcode == OPCODE_SYSTEM) && (is_write || s.funct3 inside
                   {FUNCT3_CSRRS, FUNCT3_CSRRSI, FUNCT3_CSRRC, FUNCT3_CSRRCI});
        operand  = is_imm ? data_t'(s.rs1) : s.rs1_data;
        old_value = reference_read(s.addr);     // Counts before this request's edge
        write_intent = is_write || (s.rs1 != 0);
        if (is_write)
            new_value = operand;
        else if (s.funct3 inside {FUNCT3_CSRRS, FUNCT3_CSRRSI})
            new_value = old_value | operand;
        else
            new_value = old_value & ~operand;
        exp_illegal = !legal_op || !implemented(s.addr) ||
                      (s.addr[11:10] == 2'b11 && write_intent);
        if (!exp_illegal && write_intent)
            reference_write(s.addr, new_value);
        i_valid    = 1'b1;
        i_instr    = {s.addr, s.rs1, s.funct3, s.rd, s.opcode};
        i_rs1_data = s.rs1_data;
        @(negedge clock);
        i_valid = 1'b0;
        while (!o_valid)
            @(negedge clock);
        check_value("o_illegal", data_t'(o_illegal), data_t'(exp_illegal));
        check_value("o_rd_data", o_rd_data, exp_illegal ? '0 : old_value);
        check_value("o_rd_index", data_t'(o_rd_index), data_t'(s.rd));
    endtask

    initial begin
        int errors_before;
        // A mscratch write held during reset must neither commit nor raise o_valid
        i_valid    = 1'b1;
        i_retire   = 1'b0;
        i_instr    = {CSR_MSCRATCH, 5'd5, FUNCT3_CSRRW, 5'd1, OPCODE_SYSTEM};
        i_rs1_data = 32'hFFFF_FFFF;
        void'($urandom(1));
        build_table();
        limit = steps.size() * 8 + 50;
        repeat (2) @(negedge clock);
        i_valid    = 1'b0;
        i_instr    = '0;
        i_rs1_data = '0;
        @(negedge reset);
        @(negedge clock);
        foreach (steps[i]) begin
            errors_before = errors;
            run_step(steps[i]);
            $display("test %0d %-16s %s", i, steps[i].name,
                     (errors == errors_before) ? "ok" : "FAIL");
        end
        $display("%0d tests, %0d checks, %0d errors", steps.size(), checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

/* rv_csr.f */
+incdir+logic
logic/rv_isa_pkg.sv
logic/rv_csr_pkg.sv
logic/rv_csr_counters.sv
logic/rv_csr_alu.sv
logic/rv_csr_block.sv
logic/rv_csr_unit.sv
test/rv_csr_clock.sv
test/rv_csr_properties.sv
test/rv_csr_tb.sv

/* Makefile */
# Verilator build and run of the CSR unit testbench

VERILATOR ?= verilator
TOP       ?= rv_csr_tb
FILELIST  ?= rv_csr.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= sim passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
